// ==== vlog.f ====
rtl/io_pkg.sv
rtl/io_bus_if.sv
rtl/io_bus_sequencer.sv
rtl/port_decoder.sv
rtl/sysctl_port.sv
rtl/io_hub.sv
tests/io_hub_assertions.sv
tests/io_hub_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module io_hub_tb \
	-f vlog.f \
	-o io_hub_sim

./obj_dir/io_hub_sim

// ==== tests/io_hub_tb.sv ====
module io_hub_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import io_pkg::*;

	localparam int ACK_TIMEOUT = 20; // cycles per handshake phase

	typedef struct packed {
		logic       reset_before;
		port_addr_t addr;
		logic       write;
		io_size_e   size;
		io_data_t   wdata;
		io_dev_e    exp_dev;
		logic [7:0] exp_cfg;
	} access_t;

	logic       clk_sys;
	logic       reset;
	logic       req;
	logic       ack;
	port_addr_t port_address;
	logic       port_write;
	io_size_e   port_size;
	io_data_t   port_writedata;
	io_data_t   port_readdata;
	io_dev_e    dev_sel;
	port_addr_t dev_address;
	io_size_e   dev_size;
	io_data_t   dev_writedata;
	logic       dev_read;
	logic       dev_write;
	io_data_t   dev_readdata;
	logic [7:0] syscfg;

	access_t     access_q[$];
	io_data_t    dev_words [16]; // device model, one word per select
	int unsigned strobe_total;
	io_dev_e     strobe_sel;
	port_addr_t  strobe_addr;
	io_size_e    strobe_size;
	io_data_t    strobe_wdata;
	logic        strobe_wr;

	io_hub u_dut (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.req            (req),
		.ack            (ack),
		.port_address   (port_address),
		.port_write     (port_write),
		.port_size      (port_size),
		.port_writedata (port_writedata),
		.port_readdata  (port_readdata),
		.dev_sel        (dev_sel),
		.dev_address    (dev_address),
		.dev_size       (dev_size),
		.dev_writedata  (dev_writedata),
		.dev_read       (dev_read),
		.dev_write      (dev_write),
		.dev_readdata   (dev_readdata),
		.syscfg         (syscfg)
	);

	always #5 clk_sys = ~clk_sys;

	assign dev_readdata = dev_words[dev_sel];

	// record every strobe the hub puts on the device side
	always @(posedge clk_sys) begin
		if (dev_read || dev_write) begin
			strobe_total <= strobe_total + 1;
			strobe_sel   <= dev_sel;
			strobe_addr  <= dev_address;
			strobe_size  <= dev_size;
			strobe_wdata <= dev_writedata;
			strobe_wr    <= dev_write;
		end
	end

	// hdd is 32 bits wide, other devices a byte, nobody home reads FFh
	function automatic io_data_t expected_readdata(input io_dev_e dev, input io_data_t word);
		if (dev == dev_hdd0)
			return word;
		else if (dev == dev_none || dev == dev_sysctl)
			return 32'h0000_00FF;
		else
			return {24'd0, word[7:0]};
	endfunction

	task automatic stop_on_error(input string what);
		if (what != "")
			$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			stop_on_error("");
		end
	endtask

	task automatic wait_ack(input logic level, input string what);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > ACK_TIMEOUT)
				stop_on_error(what);
		end while (ack !== level);
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check("syscfg", 32'(syscfg), 32'h0000_00A2);
		check("ack", 32'(ack), 32'd0);
		check("dev_read", 32'(dev_read), 32'd0);
		check("dev_write", 32'(dev_write), 32'd0);
		check("dev_sel", 32'(dev_sel), 32'(dev_none));
	endtask

	task automatic add_entry(input logic rst, input port_addr_t addr, input logic wr,
		input io_size_e size, input io_data_t wd, input io_dev_e dev, input logic [7:0] cfg);
		access_t e;
		e.reset_before = rst;
		e.addr         = addr;
		e.write        = wr;
		e.size         = size;
		e.wdata        = wd;
		e.exp_dev      = dev;
		e.exp_cfg      = cfg;
		access_q.push_back(e);
	endtask

	task automatic run_access(input access_t e);
		io_data_t    wdata;
		io_data_t    word;
		int unsigned start_count;
		int unsigned hold;
		wdata = (e.addr == SYSCTL_PORT) ? e.wdata : $urandom; // key data only on 8888h
		word  = $urandom;
		hold  = $urandom % 8;
		@(negedge clk_sys);
		dev_words[e.exp_dev] = word;
		start_count = strobe_total;
		@(posedge clk_sys);
		req            <= 1'b1;
		port_address   <= e.addr;
		port_write     <= e.write;
		port_size      <= e.size;
		port_writedata <= wdata;
		wait_ack(1'b1, $sformatf("ack did not rise for port %h", e.addr));
		check("strobes", strobe_total - start_count, 32'd1);
		check("dev_sel", 32'(strobe_sel), 32'(e.exp_dev));
		check("dev_address", 32'(strobe_addr), 32'(e.addr));
		check("dev_size", 32'(strobe_size), 32'(e.size));
		check("dev_write", 32'(strobe_wr), 32'(e.write));
		if (e.write)
			check("dev_writedata", strobe_wdata, wdata);
		check("port_readdata", port_readdata, expected_readdata(e.exp_dev, word));
		check("syscfg", 32'(syscfg), 32'(e.exp_cfg));
		repeat (hold) begin // host holds req after ack
			@(negedge clk_sys);
			check("ack", 32'(ack), 32'd1);
		end
		@(posedge clk_sys);
		req <= 1'b0;
		wait_ack(1'b0, $sformatf("ack did not fall for port %h", e.addr));
		check("strobes", strobe_total - start_count, 32'd1);
	endtask

	task automatic build_table();
		add_entry(1'b0, 16'h0020, 1'b0, size_byte,  32'h0, dev_pic,    8'hA2);
		add_entry(1'b0, 16'h00A1, 1'b0, size_byte,  32'h0, dev_pic,    8'hA2);
		add_entry(1'b0, 16'h0061, 1'b0, size_byte,  32'h0, dev_pit,    8'hA2); // not ps2
		add_entry(1'b0, 16'h0043, 1'b1, size_byte,  32'h0, dev_pit,    8'hA2);
		add_entry(1'b0, 16'h0087, 1'b0, size_byte,  32'h0, dev_dma,    8'hA2);
		add_entry(1'b0, 16'h00DF, 1'b0, size_byte,  32'h0, dev_dma,    8'hA2);
		add_entry(1'b0, 16'h0064, 1'b0, size_byte,  32'h0, dev_ps2,    8'hA2);
		add_entry(1'b0, 16'h0071, 1'b1, size_byte,  32'h0, dev_rtc,    8'hA2);
		add_entry(1'b0, 16'h03FD, 1'b0, size_byte,  32'h0, dev_uart,   8'hA2);
		add_entry(1'b0, 16'h1234, 1'b0, size_word,  32'h0, dev_none,   8'hA2);
		add_entry(1'b0, 16'h00E0, 1'b0, size_byte,  32'h0, dev_none,   8'hA2);
		add_entry(1'b0, 16'h8888, 1'b0, size_word,  32'h0, dev_sysctl, 8'hA2);
		add_entry(1'b0, 16'h8888, 1'b1, size_word,  32'h0000_B27E, dev_sysctl, 8'hA2);
		add_entry(1'b0, 16'h8888, 1'b1, size_byte,  32'h0000_A111, dev_sysctl, 8'hA2);
		add_entry(1'b0, 16'h8888, 1'b1, size_dword, 32'h0000_A122, dev_sysctl, 8'hA2);
		add_entry(1'b0, 16'h8888, 1'b1, size_word,  32'h0000_A15C, dev_sysctl, 8'h5C);
		add_entry(1'b0, 16'h03F2, 1'b0, size_byte,  32'h0, dev_floppy, 8'h5C);
		add_entry(1'b0, 16'h01F0, 1'b0, size_dword, 32'h0, dev_hdd0,   8'h5C);
		// second boot, disk access clears the byte
		add_entry(1'b1, 16'h03F6, 1'b0, size_byte,  32'h0, dev_hdd0,   8'h00);
		add_entry(1'b0, 16'h01F7, 1'b1, size_byte,  32'h0, dev_hdd0,   8'h00);
		add_entry(1'b0, 16'h8888, 1'b1, size_word,  32'h1234_A13C, dev_sysctl, 8'h3C);
		add_entry(1'b0, 16'h03F5, 1'b1, size_byte,  32'h0, dev_floppy, 8'h3C);
		add_entry(1'b0, 16'h0000, 1'b0, size_byte,  32'h0, dev_dma,    8'h3C);
		add_entry(1'b0, 16'h8889, 1'b0, size_byte,  32'h0, dev_none,   8'h3C);
		// third boot, floppy first
		add_entry(1'b1, 16'h03F7, 1'b1, size_byte,  32'h0, dev_floppy, 8'h00);
	endtask

	initial begin
		void'($urandom(32'h8d6f));
		clk_sys        = 1'b0;
		reset          = 1'b1;
		req            = 1'b0;
		port_address   = 16'h0000;
		port_write     = 1'b0;
		port_size      = size_byte;
		port_writedata = 32'h0;
		strobe_total   = 0;
		for (int i = 0; i < 16; i++)
			dev_words[i] = $urandom;
		build_table();
		apply_reset();
		foreach (access_q[i]) begin
			if (access_q[i].reset_before)
				apply_reset();
			run_access(access_q[i]);
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== tests/io_hub_assertions.sv ====
module io_hub_assertions (
	input logic clk_sys,
	input logic reset,
	input logic req,
	input logic ack,
	input logic rd,
	input logic wr
);
	timeunit 1ns;
	timeprecision 1ps;

	logic pending; // req high with ack low
	logic pending_q;
	logic accepted;

	assign pending  = req && !ack;
	assign accepted = pending && !pending_q; // first such edge, edge N

	always_ff @(posedge clk_sys) begin
		if (reset)
			pending_q <= 1'b0;
		else
			pending_q <= pending;
	end

	strobe_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		(rd || wr) |=> !(rd || wr))
		else $error("strobe longer than one cycle");

	no_read_and_write: assert property (@(posedge clk_sys) disable iff (reset)
		!(rd && wr))
		else $error("read and write strobes high together");

	// ack driven three edges after accept, seen at the fourth sample
	ack_latency: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(ack) == $past(accepted, 4))
		else $error("ack not three cycles after accepted req");

	ack_held: assert property (@(posedge clk_sys) disable iff (reset)
		(ack && req) |=> ack)
		else $error("ack dropped while req high");

endmodule

bind io_bus_sequencer io_hub_assertions u_assert (
	.clk_sys (clk_sys),
	.reset   (reset),
	.req     (req),
	.ack     (ack),
	.rd      (bus.read),
	.wr      (bus.write)
);

// ==== rtl/io_hub.sv ====
module io_hub #(
	parameter logic [7:0] SYSCFG_RESET = io_pkg::SYSCFG_DEFAULT
) (
	input  logic               clk_sys,
	input  logic               reset,

	input  logic               req,
	output logic               ack,
	input  io_pkg::port_addr_t port_address,
	input  logic               port_write,
	input  io_pkg::io_size_e   port_size,
	input  io_pkg::io_data_t   port_writedata,
	output io_pkg::io_data_t   port_readdata,

	output io_pkg::io_dev_e    dev_sel,
	output io_pkg::port_addr_t dev_address,
	output io_pkg::io_size_e   dev_size,
	output io_pkg::io_data_t   dev_writedata,
	output logic               dev_read,
	output logic               dev_write,
	input  io_pkg::io_data_t   dev_readdata,

	output logic [7:0]         syscfg
);

	io_bus_if u_bus ();

	io_bus_sequencer u_seq (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.req            (req),
		.ack            (ack),
		.port_address   (port_address),
		.port_write     (port_write),
		.port_size      (port_size),
		.port_writedata (port_writedata),
		.port_readdata  (port_readdata),
		.dev_readdata   (dev_readdata),
		.bus            (u_bus.master)
	);

	port_decoder u_dec (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (u_bus.decoder)
	);

	sysctl_port #(
		.SYSCFG_RESET (SYSCFG_RESET)
	) u_sysctl (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (u_bus.monitor),
		.syscfg  (syscfg)
	);

	// device side sees the internal bus directly
	assign dev_sel       = u_bus.dev;
	assign dev_address   = u_bus.address;
	assign dev_size      = u_bus.size;
	assign dev_writedata = u_bus.writedata;
	assign dev_read      = u_bus.read;
	assign dev_write     = u_bus.write;

endmodule

// ==== rtl/sysctl_port.sv ====
module sysctl_port #(
	parameter logic [7:0] SYSCFG_RESET = io_pkg::SYSCFG_DEFAULT
) (
	input  logic       clk_sys,
	input  logic       reset,
	io_bus_if.monitor  bus,
	output logic [7:0] syscfg
);
	import io_pkg::*;

	logic [7:0] cfg;
	logic       in_reset; // no disk access seen yet
	logic       strobe;
	logic       disk_hit;
	logic       key_write;

	assign strobe   = bus.read | bus.write;
	assign disk_hit = (bus.dev == dev_hdd0) || (bus.dev == dev_floppy);

	assign key_write = bus.write && (bus.dev == dev_sysctl) &&
		(bus.size == size_word) && (bus.writedata[15:8] == SYSCTL_KEY);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg      <= SYSCFG_RESET;
			in_reset <= 1'b1;
		end
		else if (strobe && disk_hit && in_reset) begin
			cfg      <= 8'd0; // first boot disk access
			in_reset <= 1'b0;
		end
		else if (key_write) begin
			cfg      <= bus.writedata[7:0];
			in_reset <= 1'b0;
		end
	end

	assign syscfg = cfg;

endmodule

// ==== rtl/port_decoder.sv ====
module port_decoder (
	input  logic       clk_sys,
	input  logic       reset,
	io_bus_if.decoder  bus
);
	import io_pkg::*;

	io_dev_e next_dev;

	// aligned block of 2**low_bits ports starting at base
	function automatic logic in_block(
		input port_addr_t  a,
		input port_addr_t  base,
		input int unsigned low_bits
	);
		return (a >> low_bits) == (base >> low_bits);
	endfunction

	// first match wins
	always_comb begin
		if (in_block(bus.address, 16'h01F0, 3) || bus.address == 16'h03F6)
			next_dev = dev_hdd0;
		else if (in_block(bus.address, 16'h03F0, 3))
			next_dev = dev_floppy;
		else if (in_block(bus.address, 16'h0000, 4) ||
			in_block(bus.address, 16'h0080, 4) ||
			in_block(bus.address, 16'h00C0, 5))
			next_dev = dev_dma; // slave, page regs, master
		else if (in_block(bus.address, 16'h0020, 1) ||
			in_block(bus.address, 16'h00A0, 1))
			next_dev = dev_pic;
		else if (in_block(bus.address, 16'h0040, 2) || bus.address == 16'h0061)
			next_dev = dev_pit; // 61h is the speaker gate
		else if (in_block(bus.address, 16'h0060, 3))
			next_dev = dev_ps2;
		else if (in_block(bus.address, 16'h0070, 1))
			next_dev = dev_rtc;
		else if (in_block(bus.address, 16'h03F8, 3))
			next_dev = dev_uart;
		else if (bus.address == SYSCTL_PORT)
			next_dev = dev_sysctl;
		else
			next_dev = dev_none;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			bus.dev <= dev_none;
		else
			bus.dev <= next_dev;
	end

endmodule

// ==== rtl/io_bus_sequencer.sv ====
module io_bus_sequencer (
	input  logic               clk_sys,
	input  logic               reset,

	input  logic               req,
	output logic               ack,
	input  io_pkg::port_addr_t port_address,
	input  logic               port_write,
	input  io_pkg::io_size_e   port_size,
	input  io_pkg::io_data_t   port_writedata,
	output io_pkg::io_data_t   port_readdata,

	input  io_pkg::io_data_t   dev_readdata,

	io_bus_if.master           bus
);
	import io_pkg::*;

	seq_state_e state;
	logic       is_write;
	logic       accept;
	io_data_t   steered;

	// new access only from idle with the previous ack gone
	assign accept = (state == st_idle) && req && !ack;

	// hdd data port is 32 bits wide, everything else is a byte device
	always_comb begin
		case (bus.dev)
			dev_hdd0: begin
				steered = dev_readdata;
			end
			dev_none,
			dev_sysctl: begin
				steered = OPEN_BUS_DATA;
			end
			default: begin
				steered = {24'd0, dev_readdata[7:0]};
			end
		endcase
	end

	// payload, no reset
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			bus.address   <= port_address;
			bus.size      <= port_size;
			bus.writedata <= port_writedata;
			is_write      <= port_write;
		end

		if (state == st_access)
			port_readdata <= steered; // dev_sel valid since last edge
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= st_idle;
			ack       <= 1'b0;
			bus.read  <= 1'b0;
			bus.write <= 1'b0;
		end
		else begin
			bus.read  <= 1'b0;
			bus.write <= 1'b0;

			case (state)
				st_idle: begin
					if (accept)
						state <= st_decode;
				end

				st_decode: begin
					state <= st_access; // decoder registers dev at this edge
				end

				st_access: begin
					bus.read  <= !is_write;
					bus.write <= is_write;
					state     <= st_done;
				end

				st_done: begin
					if (!ack) begin
						ack <= 1'b1;
					end
					else if (!req) begin
						ack   <= 1'b0;
						state <= st_idle;
					end
				end

				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

// ==== rtl/io_bus_if.sv ====
interface io_bus_if;
	import io_pkg::*;

	port_addr_t address;
	io_size_e   size;
	io_data_t   writedata;
	logic       read;  // one-cycle strobe
	logic       write; // one-cycle strobe
	io_dev_e    dev;   // registered decode of address

	modport master (
		output address, size, writedata, read, write,
		input  dev
	);

	modport decoder (
		input  address,
		output dev
	);

	modport monitor (
		input dev, size, writedata, read, write
	);

endinterface

// ==== rtl/io_pkg.sv ====
package io_pkg;

	typedef logic [15:0] port_addr_t;
	typedef logic [31:0] io_data_t;

	typedef enum logic [1:0] {
		size_byte  = 2'd0,
		size_word  = 2'd1,
		size_dword = 2'd2
	} io_size_e;

	typedef enum logic [3:0] {
		dev_none   = 4'd0,
		dev_hdd0   = 4'd1,
		dev_floppy = 4'd2,
		dev_dma    = 4'd3,
		dev_pic    = 4'd4,
		dev_pit    = 4'd5,
		dev_ps2    = 4'd6,
		dev_rtc    = 4'd7,
		dev_uart   = 4'd8,
		dev_sysctl = 4'd9
	} io_dev_e;

	typedef enum logic [1:0] {
		st_idle   = 2'd0,
		st_decode = 2'd1, // address on bus, decode in flight
		st_access = 2'd2,
		st_done   = 2'd3  // ack phase
	} seq_state_e;

	localparam port_addr_t SYSCTL_PORT = 16'h8888;
	localparam logic [7:0] SYSCTL_KEY = 8'hA1; // must sit in writedata[15:8]
	localparam logic [7:0] SYSCFG_DEFAULT = 8'hA2;

	// what an unclaimed port reads back
	localparam io_data_t OPEN_BUS_DATA = 32'h0000_00FF;

endpackage
